/* hazardPkg.sv */
// 16-bit eight-register ISA only; opcode groups are matched on bits 15:13, so an unused group code decodes as a no-read NOP-like instruction
package hazardPkg;

    // widths fixed by the ISA
    typedef logic [15:0] inst_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  regIdx_t;
    typedef logic [1:0]  wbSel_t;
    typedef logic [3:0]  fwCtrl_t;

    // which register fields an instruction reads
    typedef enum logic [2:0] {
        noneRead,
        rsOnly,
        rsRd,
        rsRt,
        passThrough
    } opClass_e;

    // instruction field bounds
    localparam int OPC_HI = 15;
    localparam int OPC_LO = 11;
    localparam int RS_HI  = 10;
    localparam int RS_LO  = 8;
    localparam int SB_HI  = 7;
    localparam int SB_LO  = 5;
    localparam int RD_HI  = 4;
    localparam int RD_LO  = 2;

    // single opcodes
    localparam opcode_t OP_HALT  = 5'b00000;
    localparam opcode_t OP_NOP   = 5'b00001;
    localparam opcode_t OP_SIIC  = 5'b00010;
    localparam opcode_t OP_RTI   = 5'b00011;
    localparam opcode_t OP_J     = 5'b00100;
    localparam opcode_t OP_JR    = 5'b00101;
    localparam opcode_t OP_JAL   = 5'b00110;
    localparam opcode_t OP_JALR  = 5'b00111;
    localparam opcode_t OP_ST    = 5'b10000;
    localparam opcode_t OP_LD    = 5'b10001;
    localparam opcode_t OP_SLBI  = 5'b10010;
    localparam opcode_t OP_STU   = 5'b10011;
    localparam opcode_t OP_LBI   = 5'b11000;
    localparam opcode_t OP_BTR   = 5'b11001;
    localparam opcode_t OP_BITOP = 5'b11010;
    localparam opcode_t OP_ARITH = 5'b11011;

    // opcode groups, upper three bits
    localparam logic [2:0] GRP_JUMP   = 3'b001;
    localparam logic [2:0] GRP_IMMA   = 3'b010;
    localparam logic [2:0] GRP_BRANCH = 3'b011;
    localparam logic [2:0] GRP_IMMB   = 3'b101;
    localparam logic [2:0] GRP_SET    = 3'b111;

    // link register for JAL/JALR
    localparam regIdx_t R7_IDX = 3'd7;

    // write-back source
    localparam wbSel_t WB_NONE = 2'b00;
    localparam wbSel_t WB_MEM  = 2'b01;
    localparam wbSel_t WB_ALU  = 2'b10;
    localparam wbSel_t WB_IMM  = 2'b11;

    // forwarding word, bit 3 forward, bit 2 from X, bits 1:0 source
    localparam int FW_BIT  = 3;
    localparam int FW_XBIT = 2;
    localparam logic [1:0] FW_SRC_ALU = 2'b00;
    localparam logic [1:0] FW_SRC_IMM = 2'b01;
    localparam logic [1:0] FW_SRC_MEM = 2'b10;

    // bubble word, opcode 00001 and zeros
    localparam inst_t NOP_INST = {OP_NOP, 11'b0};

endpackage

/* instClassify.sv */
// purely combinational; siic and rti are reported as passThrough and never marked as writers, JAL/JALR results count as ALU write-back
`timescale 1ns/10ps

module instClassify import hazardPkg::*; (
    input  inst_t    inst,
    output opClass_e opClass,
    output regIdx_t  srcA,
    output regIdx_t  srcB,
    output logic     regWrt,
    output regIdx_t  wrtReg,
    output wbSel_t   wbDataSel,
    output logic     branchInst
);

    opcode_t    opcode;
    logic [2:0] opGroup;
    regIdx_t    rsField;
    regIdx_t    sbField;
    regIdx_t    rdField;

    assign opcode  = inst[OPC_HI:OPC_LO];
    assign opGroup = opcode[4:2];
    assign rsField = inst[RS_HI:RS_LO];
    assign sbField = inst[SB_HI:SB_LO];
    assign rdField = inst[RD_HI:RD_LO];

    // source fields sit in fixed places, class says which are real
    assign srcA = rsField;
    assign srcB = sbField;

    always_comb begin
        opClass    = noneRead;
        regWrt     = 1'b0;
        wrtReg     = '0;
        wbDataSel  = WB_NONE;
        branchInst = 1'b0;

        if (opGroup == GRP_SET) begin
            // seq/slt/sle/sco, R-format
            opClass   = rsRt;
            regWrt    = 1'b1;
            wrtReg    = rdField;
            wbDataSel = WB_ALU;
        end else if (opGroup == GRP_BRANCH) begin
            opClass    = rsOnly;
            branchInst = 1'b1;
        end else if (opGroup == GRP_JUMP) begin
            branchInst = 1'b1;
            // register-relative jumps read rs
            if (opcode == OP_JR || opcode == OP_JALR) begin
                opClass = rsOnly;
            end
            // linking jumps write R7
            if (opcode == OP_JAL || opcode == OP_JALR) begin
                regWrt    = 1'b1;
                wrtReg    = R7_IDX;
                wbDataSel = WB_ALU;
            end
        end else if (opGroup == GRP_IMMA || opGroup == GRP_IMMB) begin
            // immediate ALU ops, result in bits 7:5
            opClass   = rsOnly;
            regWrt    = 1'b1;
            wrtReg    = sbField;
            wbDataSel = WB_ALU;
        end else begin
            case (opcode)
                OP_ST: begin
                    opClass = rsRd;
                end
                OP_STU: begin
                    // stores rd, writes updated address back to rs
                    opClass   = rsRd;
                    regWrt    = 1'b1;
                    wrtReg    = rsField;
                    wbDataSel = WB_ALU;
                end
                OP_LD: begin
                    opClass   = rsOnly;
                    regWrt    = 1'b1;
                    wrtReg    = sbField;
                    wbDataSel = WB_MEM;
                end
                OP_SLBI: begin
                    opClass   = rsOnly;
                    regWrt    = 1'b1;
                    wrtReg    = rsField;
                    wbDataSel = WB_ALU;
                end
                OP_LBI: begin
                    regWrt    = 1'b1;
                    wrtReg    = rsField;
                    wbDataSel = WB_IMM;
                end
                OP_BTR: begin
                    opClass   = rsOnly;
                    regWrt    = 1'b1;
                    wrtReg    = rdField;
                    wbDataSel = WB_ALU;
                end
                OP_ARITH, OP_BITOP: begin
                    opClass   = rsRt;
                    regWrt    = 1'b1;
                    wrtReg    = rdField;
                    wbDataSel = WB_ALU;
                end
                OP_SIIC, OP_RTI: begin
                    opClass = passThrough;
                end
                // halt, nop and unused codes read and write nothing
                default: begin
                    opClass = noneRead;
                end
            endcase
        end
    end

endmodule

/* hazardDet.sv */
// zero-latency combinational check; W-stage writers are ignored since the register file writes before it reads, fwA/fwB are zero whenever pcNop is high
`timescale 1ns/10ps

module hazardDet import hazardPkg::*; (
    input  opClass_e opClass,
    input  regIdx_t  srcA,
    input  regIdx_t  srcB,
    input  logic     regWrtD,
    input  logic     regWrtX,
    input  logic     regWrtM,
    input  logic     regWrtW,
    input  regIdx_t  wrtRegD,
    input  regIdx_t  wrtRegX,
    input  regIdx_t  wrtRegM,
    input  regIdx_t  wrtRegW,
    input  wbSel_t   wbDataSelD,
    input  wbSel_t   wbDataSelX,
    input  logic     branchInstD,
    input  logic     branchInstX,
    input  logic     branchInstM,
    input  logic     branchInstW,
    input  inst_t    fetchInst,
    output inst_t    nextInst,
    output logic     pcNop,
    output fwCtrl_t  fwA,
    output fwCtrl_t  fwB
);

    logic    useA;
    logic    useB;
    logic    stallA;
    logic    stallB;
    logic    branchBusy;
    logic    ctrlStall;
    fwCtrl_t rawA;
    fwCtrl_t rawB;

    // write-back select to forwarding data source
    function automatic logic [1:0] fwSrc(input wbSel_t sel);
        case (sel)
            WB_IMM:  return FW_SRC_IMM;
            WB_MEM:  return FW_SRC_MEM;
            default: return FW_SRC_ALU;
        endcase
    endfunction

    // one source against the D/X/M writers
    // returns the forwarding word, stall through the output argument
    function automatic fwCtrl_t srcCheck(
        input  regIdx_t src,
        input  logic    used,
        output logic    stall
    );
        logic    hitD;
        logic    hitX;
        logic    hitM;
        logic    loadUse;
        fwCtrl_t fw;

        hitD    = regWrtD && (wrtRegD == src);
        hitX    = regWrtX && (wrtRegX == src);
        hitM    = regWrtM && (wrtRegM == src);
        // load data not ready until the load reaches X
        loadUse = hitD && (wbDataSelD == WB_MEM);

        // M result is past the forward paths, wait for W
        stall = used && (hitM || loadUse);

        fw = '0;
        if (used && (hitD || hitX) && !loadUse) begin
            fw[FW_BIT] = 1'b1;
            // youngest producer wins, X only if D misses
            fw[FW_XBIT] = !hitD;
            fw[1:0]     = hitD ? fwSrc(wbDataSelD) : fwSrc(wbDataSelX);
        end
        return fw;
    endfunction

    // rs read by every class except no-read and pass-through
    assign useA = (opClass != noneRead) && (opClass != passThrough);
    // bits 7:5 read only by stores and R-format ops
    assign useB = (opClass == rsRd) || (opClass == rsRt);

    assign branchBusy = branchInstD | branchInstX | branchInstM | branchInstW;
    // siic and rti go through even with a branch in flight
    assign ctrlStall  = branchBusy && (opClass != passThrough);

    always_comb begin
        rawA = srcCheck(srcA, useA, stallA);
        rawB = srcCheck(srcB, useB, stallB);
    end

    assign pcNop = stallA | stallB | ctrlStall;

    // held instruction becomes a bubble, fetch repeats it next cycle
    assign nextInst = pcNop ? NOP_INST : fetchInst;

    // the bubble reads nothing
    assign fwA = pcNop ? fwCtrl_t'(0) : rawA;
    assign fwB = pcNop ? fwCtrl_t'(0) : rawB;

endmodule

/* stageTracker.sv */
// one-cycle issue register plus D/X/M/W writer pipe; wbDataSel only kept through X, as nothing later needs it
`timescale 1ns/10ps

module stageTracker import hazardPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  inst_t   nextInst,
    input  fwCtrl_t fwA,
    input  fwCtrl_t fwB,
    input  logic    regWrtIn,
    input  regIdx_t wrtRegIn,
    input  wbSel_t  wbDataSelIn,
    input  logic    branchInIn,
    output logic    regWrtD,
    output logic    regWrtX,
    output logic    regWrtM,
    output logic    regWrtW,
    output regIdx_t wrtRegD,
    output regIdx_t wrtRegX,
    output regIdx_t wrtRegM,
    output regIdx_t wrtRegW,
    output wbSel_t  wbDataSelD,
    output wbSel_t  wbDataSelX,
    output logic    branchInstD,
    output logic    branchInstX,
    output logic    branchInstM,
    output logic    branchInstW,
    output inst_t   issuedInst,
    output fwCtrl_t fwCntrlA,
    output fwCtrl_t fwCntrlB
);

    // issue register, aligned forwarding words
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issuedInst <= NOP_INST;
            fwCntrlA   <= '0;
            fwCntrlB   <= '0;
        end else begin
            issuedInst <= nextInst;
            fwCntrlA   <= fwA;
            fwCntrlB   <= fwB;
        end
    end

    // writer control, reset to bubbles everywhere
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWrtD     <= 1'b0;
            regWrtX     <= 1'b0;
            regWrtM     <= 1'b0;
            regWrtW     <= 1'b0;
            branchInstD <= 1'b0;
            branchInstX <= 1'b0;
            branchInstM <= 1'b0;
            branchInstW <= 1'b0;
            wbDataSelD  <= WB_NONE;
            wbDataSelX  <= WB_NONE;
        end else begin
            regWrtD     <= regWrtIn;
            regWrtX     <= regWrtD;
            regWrtM     <= regWrtX;
            regWrtW     <= regWrtM;
            branchInstD <= branchInIn;
            branchInstX <= branchInstD;
            branchInstM <= branchInstX;
            branchInstW <= branchInstM;
            wbDataSelD  <= wbDataSelIn;
            wbDataSelX  <= wbDataSelD;
        end
    end

    // destination index per stage
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrtRegD <= '0;
            wrtRegX <= '0;
            wrtRegM <= '0;
            wrtRegW <= '0;
        end else begin
            wrtRegD <= wrtRegIn;
            wrtRegX <= wrtRegD;
            wrtRegM <= wrtRegX;
            wrtRegW <= wrtRegM;
        end
    end

endmodule

/* hazardTop.sv */
// fetchInst must be stable before the rising edge and repeated while pcNop is high; no datapath behind it
`timescale 1ns/10ps

module hazardTop import hazardPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  inst_t   fetchInst,
    output logic    pcNop,
    output inst_t   issuedInst,
    output fwCtrl_t fwCntrlA,
    output fwCtrl_t fwCntrlB
);

    // fetched instruction decode
    opClass_e fetchClass;
    regIdx_t  fetchSrcA;
    regIdx_t  fetchSrcB;

    // detector result
    inst_t    nextInst;
    fwCtrl_t  fwA;
    fwCtrl_t  fwB;

    // issued instruction writer info
    logic     issueWrt;
    regIdx_t  issueReg;
    wbSel_t   issueWbSel;
    logic     issueBranch;

    // stage writers back to the detector
    logic     regWrtD;
    logic     regWrtX;
    logic     regWrtM;
    logic     regWrtW;
    regIdx_t  wrtRegD;
    regIdx_t  wrtRegX;
    regIdx_t  wrtRegM;
    regIdx_t  wrtRegW;
    wbSel_t   wbDataSelD;
    wbSel_t   wbDataSelX;
    logic     branchInstD;
    logic     branchInstX;
    logic     branchInstM;
    logic     branchInstW;

    instClassify classFetch (
        .inst(fetchInst), .opClass(fetchClass), .srcA(fetchSrcA), .srcB(fetchSrcB),
        .regWrt(), .wrtReg(), .wbDataSel(), .branchInst()
    );

    hazardDet hazardDet (
        .opClass(fetchClass), .srcA(fetchSrcA), .srcB(fetchSrcB),
        .regWrtD(regWrtD), .regWrtX(regWrtX), .regWrtM(regWrtM), .regWrtW(regWrtW),
        .wrtRegD(wrtRegD), .wrtRegX(wrtRegX), .wrtRegM(wrtRegM), .wrtRegW(wrtRegW),
        .wbDataSelD(wbDataSelD), .wbDataSelX(wbDataSelX),
        .branchInstD(branchInstD), .branchInstX(branchInstX),
        .branchInstM(branchInstM), .branchInstW(branchInstW),
        .fetchInst(fetchInst), .nextInst(nextInst), .pcNop(pcNop), .fwA(fwA), .fwB(fwB)
    );

    // second decoder works on what actually issues, bubbles included
    instClassify classIssue (
        .inst(nextInst), .opClass(), .srcA(), .srcB(),
        .regWrt(issueWrt), .wrtReg(issueReg), .wbDataSel(issueWbSel), .branchInst(issueBranch)
    );

    stageTracker stageTracker (
        .clk(clk), .rstN(rstN), .nextInst(nextInst), .fwA(fwA), .fwB(fwB),
        .regWrtIn(issueWrt), .wrtRegIn(issueReg), .wbDataSelIn(issueWbSel),
        .branchInIn(issueBranch),
        .regWrtD(regWrtD), .regWrtX(regWrtX), .regWrtM(regWrtM), .regWrtW(regWrtW),
        .wrtRegD(wrtRegD), .wrtRegX(wrtRegX), .wrtRegM(wrtRegM), .wrtRegW(wrtRegW),
        .wbDataSelD(wbDataSelD), .wbDataSelX(wbDataSelX),
        .branchInstD(branchInstD), .branchInstX(branchInstX),
        .branchInstM(branchInstM), .branchInstW(branchInstW),
        .issuedInst(issuedInst), .fwCntrlA(fwCntrlA), .fwCntrlB(fwCntrlB)
    );

endmodule

/* tbClkGen.sv */
// testbench only; 4 ns clock starting low, rstN held low over the first two rising edges
`timescale 1ns/10ps

module tbClkGen (
    output logic clk,
    output logic rstN
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release 1 ns after the second edge, away from any edge
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

/* hazardTb.sv */
// reads hazardPatterns.txt from the project root; records of six hex words, a record with test number ff ends the list
`timescale 1ns/10ps

module hazardTb import hazardPkg::*; ();

    localparam int          REC_WORDS = 6;
    localparam int          MAX_RECS  = 64;
    localparam int          MEM_WORDS = REC_WORDS * MAX_RECS;
    localparam logic [15:0] END_TEST  = 16'h00ff;

    logic    clk;
    logic    rstN;
    inst_t   fetchInst;
    logic    pcNop;
    inst_t   issuedInst;
    fwCtrl_t fwCntrlA;
    fwCtrl_t fwCntrlB;

    // raw pattern words, six per cycle
    logic [15:0] patMem [0:MEM_WORDS-1];
    int          numPats;
    bit          loaded;
    int          errCount;
    int          checkCount;
    int          testErrs;
    int          testChecks;

    tbClkGen clkGen (
        .clk(clk),
        .rstN(rstN)
    );

    hazardTop i_hazardTop (
        .clk(clk),
        .rstN(rstN),
        .fetchInst(fetchInst),
        .pcNop(pcNop),
        .issuedInst(issuedInst),
        .fwCntrlA(fwCntrlA),
        .fwCntrlB(fwCntrlB)
    );

    // one line per wrong value
    task automatic flagMismatch(input string name, input logic [15:0] expVal,
                                input logic [15:0] actVal);
        $display("[FAIL] t=%0.2f ns %s expected %h got %h", $realtime, name, expVal, actVal);
        errCount++;
        testErrs++;
    endtask

    // result line for a finished test, then clear its counters
    task automatic closeTest(input int testNum);
        if (testErrs == 0) begin
            $display("test %0d: passed, %0d checks", testNum, testChecks);
        end else begin
            $display("test %0d: failed, %0d of %0d checks wrong", testNum, testErrs, testChecks);
        end
        testErrs   = 0;
        testChecks = 0;
    endtask

    // fill depends on the address, so unread words never look like an end record
    task automatic loadPatterns();
        for (int a = 0; a < MEM_WORDS; a++) begin
            patMem[a] = 16'(a) ^ 16'ha5a5;
        end
        $readmemh("hazardPatterns.txt", patMem);
        numPats = 0;
        // first end record sets the count
        for (int r = MAX_RECS - 1; r >= 0; r--) begin
            if (patMem[r * REC_WORDS] == END_TEST) begin
                numPats = r;
            end
        end
    endtask

    initial begin
        int      base;
        int      curTest;
        logic    expNop;
        inst_t   expInst;
        fwCtrl_t expA;
        fwCtrl_t expB;

        fetchInst  = NOP_INST;
        errCount   = 0;
        checkCount = 0;
        testErrs   = 0;
        testChecks = 0;
        loaded     = 1'b0;
        loadPatterns();

        if (numPats < 1) begin
            $display("pattern file is missing, empty or has no end record");
            errCount++;
        end else begin
            loaded = 1'b1;

            // state straight out of reset, before any edge clocks it
            wait (rstN === 1'b1);
            #0.5;
            if (pcNop !== 1'b0) begin
                flagMismatch("pcNop", 16'(1'b0), 16'(pcNop));
            end
            if (issuedInst !== NOP_INST) begin
                flagMismatch("issuedInst", NOP_INST, issuedInst);
            end
            if (fwCntrlA !== 4'h0) begin
                flagMismatch("fwCntrlA", 16'(4'h0), 16'(fwCntrlA));
            end
            if (fwCntrlB !== 4'h0) begin
                flagMismatch("fwCntrlB", 16'(4'h0), 16'(fwCntrlB));
            end
            testChecks += 4;
            checkCount += 4;
            closeTest(0);

            @(posedge clk);
            #1;
            curTest = int'(patMem[0]);
            for (int p = 0; p < numPats; p++) begin
                base = p * REC_WORDS;
                if (int'(patMem[base]) != curTest) begin
                    closeTest(curTest);
                    curTest = int'(patMem[base]);
                end
                expNop  = patMem[base + 2][0];
                expInst = patMem[base + 3];
                expA    = patMem[base + 4][3:0];
                expB    = patMem[base + 5][3:0];

                // 1 ns after the edge
                fetchInst = patMem[base + 1];

                // combinational stall, just before the next edge
                #2;
                if (pcNop !== expNop) begin
                    flagMismatch("pcNop", 16'(expNop), 16'(pcNop));
                end

                // registered outputs after the edge
                @(posedge clk);
                #1;
                if (issuedInst !== expInst) begin
                    flagMismatch("issuedInst", expInst, issuedInst);
                end
                if (fwCntrlA !== expA) begin
                    flagMismatch("fwCntrlA", 16'(expA), 16'(fwCntrlA));
                end
                if (fwCntrlB !== expB) begin
                    flagMismatch("fwCntrlB", 16'(expB), 16'(fwCntrlB));
                end
                testChecks += 4;
                checkCount += 4;
            end
            closeTest(curTest);
        end

        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog, one clock per pattern plus room for reset
    initial begin
        wait (loaded);
        #(numPats * 4 + 100);
        $display("run timed out, %0d pattern cycles did not finish in time", numPats);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* hazardPatterns.txt */
// test fetchInst pcNop issuedInst fwCntrlA fwCntrlB, all hex
// pcNop holds during the cycle, the other three after the following edge
// 1: independent ALU ops
01 D94C 0 D94C 0 0
01 DCB8 0 DCB8 0 0
01 D940 0 D940 0 0
01 47A1 0 47A1 0 0
// 2: D and X forwards, LBI source, D wins over X
02 DD84 0 DD84 8 0
02 DBA8 0 DBA8 0 C
02 C412 0 C412 0 0
02 DCCC 0 DCCC 9 0
02 44C2 0 44C2 D 0
02 D818 0 D818 0 0
02 DE1C 0 DE1C 8 0
// 3: load-use
03 8840 0 8840 0 0
03 DA14 1 0800 0 0
03 DA14 0 DA14 E 0
// 4: M stalls, W does nothing
04 DA64 1 0800 0 0
04 DA64 0 DA64 0 0
// 5: branch, JR with siic and rti in the window
05 6004 0 6004 0 0
05 D810 1 0800 0 0
05 D810 1 0800 0 0
05 D810 1 0800 0 0
05 D810 1 0800 0 0
05 D810 0 D810 0 0
05 2B00 0 2B00 0 0
05 1000 0 1000 0 0
05 1800 0 1800 0 0
05 D810 1 0800 0 0
05 D810 1 0800 0 0
05 D810 0 D810 0 0
// 6: ST, rs-only, nop, halt, J
06 40A3 0 40A3 0 0
06 84A0 0 84A0 C 8
06 8080 1 0800 0 0
06 8080 0 8080 0 0
06 8860 0 8860 0 0
06 4161 0 4161 0 0
06 4361 0 4361 8 0
06 8900 0 8900 0 0
06 0800 0 0800 0 0
06 0300 0 0300 0 0
06 2000 0 2000 0 0
06 0800 1 0800 0 0
ff 0000 0 0000 0 0

/* sim.f */
hazardPkg.sv
instClassify.sv
hazardDet.sv
stageTracker.sv
hazardTop.sv
tbClkGen.sv
hazardTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build with Verilator from sim.f, run from the project root, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module hazardTb -f sim.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VhazardTb > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
